// File: bench/ch1_input.txt
# name op sel data cycles expected; sel is register 10 to 14, data and expected are hex
# cycles is the wait before a check, the length of a wait, or the bound of an align or pulse
rb_nr10     write  10 5a 0     0
rb_nr10     read   10 00 0     da
rb_nr11     write  11 96 0     0
rb_nr11     read   11 00 0     bf
rb_nr12     write  12 a5 0     0
rb_nr12     read   12 00 0     a5
rb_nr13     write  13 12 0     0
rb_nr13     read   13 00 0     ff
rb_nr14     write  14 45 0     0
rb_nr14     read   14 00 0     ff
duty_setup  write  10 00 0     0
duty_setup  write  12 f0 0     0
duty_setup  write  11 80 0     0
duty_setup  write  13 e0 0     0
duty_trig   write  14 87 0     0
duty_trig   active 0  00 1     1
duty_pos0   sample 0  00 64    f
duty_pos1   sample 0  00 128   0
duty_pos2   sample 0  00 128   0
duty_pos3   sample 0  00 128   0
duty_pos4   sample 0  00 128   0
duty_pos5   sample 0  00 128   f
duty_pos6   sample 0  00 128   f
duty_pos7   sample 0  00 128   f
len_setup   write  11 bc 0     0
len_trig    write  14 c7 0     0
len_early   active 0  00 250   1
len_expired active 0  00 300   0
dac_trig    write  14 87 0     0
dac_trig    active 0  00 1     1
dac_off     write  12 00 0     0
dac_off     active 0  00 1     0
dac_off     sample 0  00 0     0
ovf_setup   write  12 f0 0     0
ovf_setup   write  10 01 0     0
ovf_setup   write  13 dc 0     0
ovf_trig    write  14 85 0     0
ovf_trig    active 0  00 1     1
ovf_off     active 0  00 2     0
wb_sync     align  0  60 256   0
wb_setup    write  10 1a 0     0
wb_setup    write  11 00 0     0
wb_setup    write  13 f8 0     0
wb_trig     write  14 87 0     0
wb_hold     wait   0  00 150   0
wb_stop     write  10 00 0     0
wb_pulse    pulse  0  00 40000 818

// File: bench/ch1_tb.sv
`timescale 1ns/1ps
`include "ch1_consts.svh"

module ch1_tb;

	logic                   clk;
	logic                   rst_n;
	logic                   wr;
	logic                   rd;
	logic                   ff10;
	logic                   ff11;
	logic                   ff12;
	logic                   ff13;
	logic                   ff14;
	logic [`CH1_DATA_W-1:0] wdata;
	logic [`CH1_DATA_W-1:0] rdata;
	ch1_pkg::vol_t          sample;
	logic                   active;

	string op_name[$];
	string op_kind[$];
	int    op_sel[$];
	int    op_data[$];
	int    op_cycles[$];
	int    op_expect[$];
	int    limit_cycles;
	int    cyc; // posedges since reset release

	ch1_top uut (
		.clk(clk), .rst_n(rst_n), .wr(wr), .rd(rd),
		.ff10(ff10), .ff11(ff11), .ff12(ff12), .ff13(ff13), .ff14(ff14),
		.wdata(wdata), .rdata(rdata), .sample(sample), .active(active)
	);

	always #20 clk = ~clk;

	// sweep steps take effect on the edge that brings cyc % 256 to 192
	always @(posedge clk) begin
		if (!rst_n)
			cyc <= 0;
		else
			cyc <= cyc + 1;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual)
			abort_run($sformatf("[ERROR] %s expected %0h actual %0h", name, expected, actual));
	endtask

	task automatic select_reg(input int num);
		ff10 = (num == 10);
		ff11 = (num == 11);
		ff12 = (num == 12);
		ff13 = (num == 13);
		ff14 = (num == 14);
	endtask

	task automatic write_reg(input int num, input int value);
		select_reg(num);
		wdata = value[`CH1_DATA_W-1:0];
		wr    = 1'b1;
		@(negedge clk); // taken on the rising edge in between
		wr    = 1'b0;
		select_reg(0);
	endtask

	task automatic read_reg(input string name, input int num, input int expected);
		select_reg(num);
		rd = 1'b1;
		@(negedge clk);
		check_value(name, expected, rdata);
		rd = 1'b0;
		select_reg(0);
	endtask

	// length in cycles of the next complete nonzero stretch of sample
	task automatic measure_pulse(output int len);
		len = 0;
		while (sample != 4'h0)
			@(negedge clk);
		while (sample == 4'h0)
			@(negedge clk);
		while (sample != 4'h0) begin
			len = len + 1;
			@(negedge clk);
		end
	endtask

	task automatic load_ops();
		int    fd;
		int    n;
		string line;
		string name;
		string kind;
		int    sel;
		int    data;
		int    cycles;
		int    expected;
		fd = $fopen("bench/ch1_input.txt", "r");
		if (fd == 0) begin
			abort_run("could not open the stimulus file bench/ch1_input.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (line.len() > 1 && line[0] != "#") begin // skip comments and blanks
					n = $sscanf(line, "%s %s %d %h %d %h", name, kind, sel, data, cycles,
						expected);
					if (n != 6) begin
						abort_run($sformatf("stimulus line could not be parsed: %s", line));
					end else begin
						op_name.push_back(name);
						op_kind.push_back(kind);
						op_sel.push_back(sel);
						op_data.push_back(data);
						op_cycles.push_back(cycles);
						op_expect.push_back(expected);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	initial begin : watchdog
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		abort_run($sformatf("the run timed out after %0d clock cycles", limit_cycles));
	end

	initial begin : main_flow
		int i;
		int len;
		clk          = 1'b0;
		rst_n        = 1'b0;
		wr           = 1'b0;
		rd           = 1'b0;
		wdata        = '0;
		limit_cycles = 0;
		select_reg(0);
		load_ops();
		len = 10 + 200 + 4 * op_kind.size(); // reset and margin plus one cycle per access
		for (i = 0; i < op_kind.size(); i++)
			len = len + op_cycles[i];
		limit_cycles = len;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		for (i = 0; i < op_kind.size(); i++) begin
			if (op_kind[i] == "write") begin
				write_reg(op_sel[i], op_data[i]);
			end else if (op_kind[i] == "read") begin
				read_reg(op_name[i], op_sel[i], op_expect[i]);
			end else if (op_kind[i] == "wait") begin
				repeat (op_cycles[i]) @(negedge clk);
			end else if (op_kind[i] == "sample") begin
				repeat (op_cycles[i]) @(negedge clk);
				check_value(op_name[i], op_expect[i], sample);
			end else if (op_kind[i] == "active") begin
				repeat (op_cycles[i]) @(negedge clk);
				check_value(op_name[i], op_expect[i], active);
			end else if (op_kind[i] == "align") begin
				while ((cyc % op_cycles[i]) != op_data[i]) // line up with the frame steps
					@(negedge clk);
			end else if (op_kind[i] == "pulse") begin
				measure_pulse(len);
				check_value(op_name[i], op_expect[i], len);
			end else begin
				abort_run($sformatf("unknown operation %s in test %s", op_kind[i], op_name[i]));
			end
		end
		$display("** PASS **");
		$finish;
	end

endmodule

// File: include/ch1_consts.svh
`ifndef CH1_CONSTS_SVH
`define CH1_CONSTS_SVH

// clk cycles per frequency timer tick
`define CH1_TIMER_DIV 4

// clk cycles per frame sequencer step, kept short for simulation
`define CH1_STEP_DIV 64

// cpu data bus width
`define CH1_DATA_W 8

`endif

// File: project.f
+incdir+include
source/ch1_pkg.sv
source/ch1_regs.sv
source/ch1_frame_seq.sv
source/ch1_sweep.sv
source/ch1_freq_timer.sv
source/ch1_duty_env.sv
source/ch1_top.sv
bench/ch1_tb.sv

// File: source/ch1_duty_env.sv
`timescale 1ns/1ps

module ch1_duty_env (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              trig,
	input  logic [2:0]        duty_pos,
	input  ch1_pkg::duty_t    duty,
	input  ch1_pkg::vol_t     env_init,
	input  logic              env_up,
	input  ch1_pkg::period3_t env_period,
	input  logic              env_tick,
	input  logic              len_en,
	input  logic              len_load,
	input  ch1_pkg::len_t     len_data,
	input  logic              len_tick,
	input  logic              sweep_off,
	input  logic              dac_on,
	output ch1_pkg::vol_t     sample,
	output logic              active
);

	logic [7:0]        pattern;
	logic              duty_bit;
	ch1_pkg::vol_t     volume;
	ch1_pkg::period3_t env_cnt;
	ch1_pkg::len_t     len_cnt;
	logic              len_done;
	logic              len_expire;

	always_comb begin
		case (duty)
			2'd0:    pattern = 8'b0000_0001; // 12.5 %
			2'd1:    pattern = 8'b1000_0001; // 25 %
			2'd2:    pattern = 8'b1000_0111; // 50 %
			default: pattern = 8'b0111_1110; // 75 %
		endcase
	end

	assign duty_bit = pattern[3'd7 - duty_pos]; // msb first

	// length counts up from the loaded value, expires after 63
	assign len_expire = len_tick && len_en && !len_done && (len_cnt == 6'h3f);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			volume  <= '0;
			env_cnt <= '0;
		end else if (trig) begin
			volume  <= env_init;
			env_cnt <= env_period;
		end else if (env_tick && (env_period != 3'd0)) begin
			if (env_cnt <= 3'd1) begin
				env_cnt <= env_period;
				if (env_up && (volume != 4'hf))
					volume <= volume + 4'd1;
				else if (!env_up && (volume != 4'h0))
					volume <= volume - 4'd1;
			end else begin
				env_cnt <= env_cnt - 3'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			len_cnt  <= '0;
			len_done <= 1'b0;
		end else if (len_load) begin
			len_cnt  <= len_data;
			len_done <= 1'b0;
		end else if (trig && len_done) begin
			len_cnt  <= '0; // full 64 steps
			len_done <= 1'b0;
		end else if (len_tick && len_en && !len_done) begin
			if (len_cnt == 6'h3f) begin
				len_cnt  <= '0;
				len_done <= 1'b1;
			end else begin
				len_cnt <= len_cnt + 6'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			active <= 1'b0;
		else if (!dac_on || sweep_off || len_expire)
			active <= 1'b0;
		else if (trig)
			active <= 1'b1;
	end

	assign sample = (active && duty_bit) ? volume : 4'h0;

endmodule

// File: source/ch1_frame_seq.sv
`timescale 1ns/1ps
`include "ch1_consts.svh"

module ch1_frame_seq (
	input  logic clk,
	input  logic rst_n,
	output logic len_tick,
	output logic sweep_tick,
	output logic env_tick
);

	localparam int DIV_W = $clog2(`CH1_STEP_DIV);

	logic [DIV_W-1:0]     div_cnt;
	logic                 step_pulse;
	ch1_pkg::frame_step_t step;

	assign step_pulse = (div_cnt == DIV_W'(`CH1_STEP_DIV - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div_cnt <= '0;
			step    <= ch1_pkg::step_0;
		end else if (step_pulse) begin
			div_cnt <= '0;
			step    <= ch1_pkg::frame_step_t'(step + 3'd1); // wraps 7 -> 0
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// ticks fire on the step pulse of the current step
	always_comb begin
		len_tick   = 1'b0;
		sweep_tick = 1'b0;
		env_tick   = 1'b0;
		if (step_pulse) begin
			case (step)
				ch1_pkg::step_0, ch1_pkg::step_4: len_tick = 1'b1;
				ch1_pkg::step_2, ch1_pkg::step_6: begin
					len_tick   = 1'b1;
					sweep_tick = 1'b1;
				end
				ch1_pkg::step_7: env_tick = 1'b1;
				default: ;
			endcase
		end
	end

endmodule

// File: source/ch1_freq_timer.sv
`timescale 1ns/1ps
`include "ch1_consts.svh"

module ch1_freq_timer (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           trig,
	input  ch1_pkg::freq_t freq,
	output logic [2:0]     duty_pos
);

	localparam int PRE_W = $clog2(`CH1_TIMER_DIV);

	logic [PRE_W-1:0] pre_cnt;
	logic             tick;
	ch1_pkg::freq_t   cnt;
	logic             duty_step;

	assign tick      = (pre_cnt == PRE_W'(`CH1_TIMER_DIV - 1));
	assign duty_step = tick && (cnt == 11'h7ff); // wrap point

	// each duty position lasts (2048 - freq) ticks
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pre_cnt  <= '0;
			cnt      <= '0;
			duty_pos <= '0;
		end else if (trig) begin
			pre_cnt  <= '0;
			cnt      <= freq;
			duty_pos <= '0;
		end else begin
			if (tick)
				pre_cnt <= '0;
			else
				pre_cnt <= pre_cnt + 1'b1;
			if (duty_step) begin
				cnt      <= freq; // picks up any sweep write-back
				duty_pos <= duty_pos + 3'd1;
			end else if (tick) begin
				cnt <= cnt + 11'd1;
			end
		end
	end

endmodule

// File: source/ch1_pkg.sv
package ch1_pkg;

	typedef logic [10:0] freq_t;    // channel frequency, nr13 plus nr14[2:0]
	typedef logic [3:0]  vol_t;     // volume and output sample
	typedef logic [5:0]  len_t;     // length counter
	typedef logic [1:0]  duty_t;    // duty select
	typedef logic [2:0]  period3_t; // sweep/envelope period, sweep shift

	// frame sequencer position
	typedef enum logic [2:0] {
		step_0,
		step_1,
		step_2,
		step_3,
		step_4,
		step_5,
		step_6,
		step_7
	} frame_step_t;

endpackage

// File: source/ch1_regs.sv
`timescale 1ns/1ps
`include "ch1_consts.svh"

module ch1_regs (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    wr,
	input  logic                    rd,
	input  logic                    ff10,
	input  logic                    ff11,
	input  logic                    ff12,
	input  logic                    ff13,
	input  logic                    ff14,
	input  logic [`CH1_DATA_W-1:0]  wdata,
	input  logic                    wb_en,
	input  ch1_pkg::freq_t          wb_freq,
	output logic [`CH1_DATA_W-1:0]  rdata,
	output ch1_pkg::freq_t          freq,
	output ch1_pkg::duty_t          duty,
	output ch1_pkg::vol_t           env_init,
	output logic                    env_up,
	output ch1_pkg::period3_t       env_period,
	output ch1_pkg::period3_t       sweep_period,
	output logic                    sweep_down,
	output ch1_pkg::period3_t       sweep_shift,
	output logic                    len_en,
	output logic                    len_load,
	output ch1_pkg::len_t           len_data,
	output logic                    trig,
	output logic                    dac_on
);

	logic [4:0] sel;
	logic       one_sel;
	logic       we;
	logic [6:0] nr10;
	logic [7:0] nr12;

	assign sel     = {ff14, ff13, ff12, ff11, ff10};
	assign one_sel = (sel != 5'd0) && ((sel & (sel - 5'd1)) == 5'd0); // exactly one select
	assign we      = wr && one_sel;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			nr10     <= '0;
			duty     <= '0;
			nr12     <= '0;
			freq     <= '0;
			len_en   <= 1'b0;
			trig     <= 1'b0;
			len_load <= 1'b0;
			len_data <= '0;
		end else begin
			if (wb_en)
				freq <= wb_freq; // sweep write-back, cpu write below takes priority
			if (we && ff10)
				nr10 <= wdata[6:0];
			if (we && ff11) begin
				duty     <= wdata[7:6];
				len_data <= wdata[5:0];
			end
			if (we && ff12)
				nr12 <= wdata[7:0];
			if (we && ff13)
				freq[7:0] <= wdata[7:0];
			if (we && ff14) begin
				freq[10:8] <= wdata[2:0];
				len_en     <= wdata[6];
			end
			trig     <= we && ff14 && wdata[7]; // one cycle after the write
			len_load <= we && ff11;
		end
	end

	// readback with unused bits forced high
	always_comb begin
		rdata = '1;
		if (rd) begin
			case (sel)
				5'b00001: rdata = {1'b1, nr10};
				5'b00010: rdata = {duty, 6'h3f};
				5'b00100: rdata = nr12;
				5'b01000: rdata = 8'hff; // frequency is write only
				5'b10000: rdata = {1'b1, len_en, 6'h3f};
				default:  rdata = '1;
			endcase
		end
	end

	assign sweep_period = nr10[6:4];
	assign sweep_down   = nr10[3];
	assign sweep_shift  = nr10[2:0];
	assign env_init     = nr12[7:4];
	assign env_up       = nr12[3];
	assign env_period   = nr12[2:0];
	assign dac_on       = |nr12[7:3]; // dac powered when any of these set

endmodule

// File: source/ch1_sweep.sv
`timescale 1ns/1ps

module ch1_sweep (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              trig,
	input  logic              sweep_tick,
	input  ch1_pkg::freq_t    freq,
	input  ch1_pkg::period3_t sweep_period,
	input  logic              sweep_down,
	input  ch1_pkg::period3_t sweep_shift,
	output logic              wb_en,
	output ch1_pkg::freq_t    wb_freq,
	output logic              sweep_off
);

	ch1_pkg::freq_t    shadow;
	ch1_pkg::period3_t per_cnt;
	logic              chk_pend;
	ch1_pkg::freq_t    delta;
	logic [11:0]       next_freq;
	logic              ovf;

	// shadow +/- shadow >> shift, one extra bit to catch overflow
	assign delta     = shadow >> sweep_shift;
	assign next_freq = sweep_down ? ({1'b0, shadow} - {1'b0, delta})
	                              : ({1'b0, shadow} + {1'b0, delta});
	assign ovf       = !sweep_down && next_freq[11]; // above 2047

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			shadow    <= '0;
			per_cnt   <= '0;
			chk_pend  <= 1'b0;
			wb_en     <= 1'b0;
			wb_freq   <= '0;
			sweep_off <= 1'b0;
		end else begin
			wb_en     <= 1'b0;
			sweep_off <= 1'b0;
			if (trig) begin
				shadow   <= freq;
				per_cnt  <= sweep_period;
				chk_pend <= (sweep_shift != 3'd0); // overflow check next cycle
			end else begin
				chk_pend <= 1'b0;
				if (chk_pend && ovf)
					sweep_off <= 1'b1;
				if (sweep_tick) begin
					if (per_cnt <= 3'd1) begin
						per_cnt <= sweep_period;
						if (sweep_period != 3'd0) begin
							if (ovf) begin
								sweep_off <= 1'b1;
							end else if (sweep_shift != 3'd0) begin
								shadow  <= next_freq[10:0];
								wb_freq <= next_freq[10:0];
								wb_en   <= 1'b1; // regs take it on the next edge
							end
						end
					end else begin
						per_cnt <= per_cnt - 3'd1;
					end
				end
			end
		end
	end

endmodule

// File: source/ch1_top.sv
`timescale 1ns/1ps
`include "ch1_consts.svh"

module ch1_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   wr,
	input  logic                   rd,
	input  logic                   ff10,
	input  logic                   ff11,
	input  logic                   ff12,
	input  logic                   ff13,
	input  logic                   ff14,
	input  logic [`CH1_DATA_W-1:0] wdata,
	output logic [`CH1_DATA_W-1:0] rdata,
	output ch1_pkg::vol_t          sample,
	output logic                   active
);

	ch1_pkg::freq_t    freq;
	ch1_pkg::duty_t    duty;
	ch1_pkg::vol_t     env_init;
	logic              env_up;
	ch1_pkg::period3_t env_period;
	ch1_pkg::period3_t sweep_period;
	logic              sweep_down;
	ch1_pkg::period3_t sweep_shift;
	logic              len_en;
	logic              len_load;
	ch1_pkg::len_t     len_data;
	logic              trig;
	logic              dac_on;
	logic              wb_en;
	ch1_pkg::freq_t    wb_freq;
	logic              sweep_off;
	logic              len_tick;
	logic              sweep_tick;
	logic              env_tick;
	logic [2:0]        duty_pos;

	ch1_regs u_regs (
		.clk(clk), .rst_n(rst_n), .wr(wr), .rd(rd),
		.ff10(ff10), .ff11(ff11), .ff12(ff12), .ff13(ff13), .ff14(ff14),
		.wdata(wdata), .wb_en(wb_en), .wb_freq(wb_freq), .rdata(rdata),
		.freq(freq), .duty(duty), .env_init(env_init), .env_up(env_up),
		.env_period(env_period), .sweep_period(sweep_period), .sweep_down(sweep_down),
		.sweep_shift(sweep_shift), .len_en(len_en), .len_load(len_load),
		.len_data(len_data), .trig(trig), .dac_on(dac_on)
	);

	ch1_frame_seq u_frame_seq (
		.clk(clk), .rst_n(rst_n),
		.len_tick(len_tick), .sweep_tick(sweep_tick), .env_tick(env_tick)
	);

	ch1_sweep u_sweep (
		.clk(clk), .rst_n(rst_n), .trig(trig), .sweep_tick(sweep_tick), .freq(freq),
		.sweep_period(sweep_period), .sweep_down(sweep_down), .sweep_shift(sweep_shift),
		.wb_en(wb_en), .wb_freq(wb_freq), .sweep_off(sweep_off)
	);

	ch1_freq_timer u_freq_timer (
		.clk(clk), .rst_n(rst_n), .trig(trig), .freq(freq), .duty_pos(duty_pos)
	);

	ch1_duty_env u_duty_env (
		.clk(clk), .rst_n(rst_n), .trig(trig), .duty_pos(duty_pos), .duty(duty),
		.env_init(env_init), .env_up(env_up), .env_period(env_period),
		.env_tick(env_tick), .len_en(len_en), .len_load(len_load),
		.len_data(len_data), .len_tick(len_tick), .sweep_off(sweep_off),
		.dac_on(dac_on), .sample(sample), .active(active)
	);

endmodule
